// File: build.f
+incdir+hw
hw/tft_pkg.sv
hw/fifo_sync.sv
hw/ram_dual.sv
hw/tft_timing.sv
hw/tft_fetch.sv
hw/tft_display.sv
test/tb_tft_display.sv

// File: run.sh
#!/bin/sh
# Build and run the TFT scan-out testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_tft_display -f build.f -Mdir obj_dir -o sim_tft

out=$(./obj_dir/sim_tft)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'all tests passed'; then
	exit 0
fi
exit 1

// File: test/tb_tft_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "tft_cfg.svh"

module tb_tft_display
	import tft_pkg::*;
();

	localparam int NUM_ROWS     = 4;
	localparam int RESET_CYCLES = 16;
	localparam int CYC_FRAME    = (`TFT_H_ACTIVE + `TFT_H_BLANK) *
		(`TFT_V_ACTIVE + `TFT_V_BLANK) * `TFT_PIX_DIV;

	// One test row of memory behavior
	typedef struct packed {
		int   rdy_delay;
		int   lat;
		int   gap;
		int   frames;
		logic slow;
	} row_t;

	// rdy delay, latency, word gap, frames, mid-frame underrun expected
	row_t rows [NUM_ROWS] = '{
		'{0, 1, 1, 2, 1'b0},
		'{1, 0, 2, 2, 1'b0},
		'{60, 8, 3, 2, 1'b1},
		'{0, 0, 1, 3, 1'b0}
	};

	logic      clk = 1'b0;
	logic      n_reset = 1'b0;
	mem_req_t  mem_req;
	mem_rsp_t  mem_rsp = '0;
	tft_sync_t sync;
	pixel_t    pixel;
	logic      underrun;

	int   cur_rdy_delay;
	int   cur_lat;
	int   cur_gap;
	int   cur_frames;
	logic cur_slow;
	int   limit;
	int   checks;
	int   errors;

	tft_display i_dut (
		.clk      (clk),
		.n_reset  (n_reset),
		.mem_req  (mem_req),
		.mem_rsp  (mem_rsp),
		.sync     (sync),
		.pixel    (pixel),
		.underrun (underrun)
	);

	always #2 clk = ~clk;

	// Frame buffer contents differ for neighbouring offsets
	function automatic rgb565_t fb_word(int off);
		logic [15:0] h;
		h = 16'(off * 40503) ^ 16'h5a5a;
		return rgb565_t'(h);
	endfunction

	function automatic pixel_t expand(rgb565_t w);
		pixel_t p;
		p.r = {w.r, 3'b000};
		p.g = {w.g, 2'b00};
		p.b = {w.b, 3'b000};
		return p;
	endfunction

	task automatic check_pixel(string name, pixel_t got, pixel_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(string name, logic [23:0] got, logic [23:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// Memory model with one burst per rdy pulse and words in order
	rgb565_t word_q [$];
	int      time_q [$];
	int      now = 0;
	int      last_t;
	int      req_cnt;
	int      t;

	always @(posedge clk) begin
		if (!n_reset) begin
			word_q.delete();
			time_q.delete();
			last_t = 0;
			req_cnt = 0;
			mem_rsp <= '0;
		end else begin
			if (mem_rsp.rdy && mem_req.req) begin
				for (int j = 0; j < `TFT_BURST; j++) begin
					t = now + cur_lat + j * cur_gap;
					if (t <= last_t) begin
						t = last_t + 1;
					end
					last_t = t;
					time_q.push_back(t);
					word_q.push_back(fb_word(32'(mem_req.addr - `TFT_FB_BASE) + j));
				end
			end
			if (mem_rsp.rdy) begin
				mem_rsp.rdy <= 1'b0;
				req_cnt = 0;
			end else if (mem_req.req) begin
				if (req_cnt >= cur_rdy_delay) begin
					mem_rsp.rdy <= 1'b1;
				end else begin
					req_cnt++;
				end
			end
			if (time_q.size() > 0 && time_q[0] <= now) begin
				mem_rsp.ifrdy <= 1'b1;
				mem_rsp.data  <= word_q.pop_front();
				void'(time_q.pop_front());
			end else begin
				mem_rsp.ifrdy <= 1'b0;
			end
		end
		now++;
	end

	// Output monitor sampled mid-cycle
	int     frames_done;
	int     widx;
	int     stalls;
	int     mid_frames;
	int     line_pix;
	int     lines;
	int     bursts;
	int     pix_cyc;
	int     blank_pix;
	pixel_t last_px;
	pixel_t exp_px;
	logic   seen_de;
	logic   seen_pix;
	logic   after_rst;
	logic   prev_pix;
	logic   prev_de;
	logic   prev_vblank;

	always @(negedge clk) begin
		if (!n_reset) begin
			frames_done = 0;
			widx = 0;
			stalls = 0;
			mid_frames = 0;
			line_pix = 0;
			lines = 0;
			bursts = 0;
			pix_cyc = 0;
			blank_pix = 0;
			last_px = '0;
			seen_de = 1'b0;
			seen_pix = 1'b0;
			after_rst = 1'b1;
			prev_pix = 1'b0;
			prev_de = 1'b0;
			prev_vblank = 1'b1;
		end else begin
			if (after_rst) begin
				check_flag("mem_req.req", mem_req.req, 1'b0);
				check_flag("sync.de", sync.de, 1'b0);
				after_rst = 1'b0;
			end
			if (!seen_de && !sync.de) begin
				check_pixel("pixel", pixel, '0);
				check_flag("underrun", underrun, 1'b0);
			end
			// Underrun is cleared by the frame reset
			if (sync.vblank) begin
				check_flag("underrun", underrun, 1'b0);
				bursts = 0;
			end
			// Same values the DUT samples at the next rising edge
			if (mem_rsp.rdy && mem_req.req) begin
				check_addr("mem_req.addr", mem_req.addr,
					24'(`TFT_FB_BASE + bursts * `TFT_BURST));
				bursts++;
			end
			// Pixel clock period and horizontal blanking width
			pix_cyc++;
			if (sync.pix_clk && !prev_pix) begin
				if (seen_pix) begin
					check_count("sync.pix_clk period", pix_cyc, `TFT_PIX_DIV);
				end
				if (sync.de && !prev_de && lines > 0) begin
					check_count("sync.hblank pixels per line", blank_pix, `TFT_H_BLANK);
				end
				blank_pix = sync.hblank ? blank_pix + 1 : 0;
				seen_pix = 1'b1;
				pix_cyc = 0;
			end
			if (sync.pix_clk && !prev_pix && sync.de) begin
				seen_de = 1'b1;
				exp_px = expand(fb_word(widx));
				// An empty pop holds the previous pixel
				if (pixel != exp_px && pixel == last_px) begin
					stalls++;
				end else begin
					check_pixel("pixel", pixel, exp_px);
					widx++;
				end
				check_flag("underrun", underrun, stalls != 0);
				last_px = pixel;
				line_pix++;
			end
			if (prev_de && !sync.de) begin
				check_count("de samples per line", line_pix, `TFT_H_ACTIVE);
				line_pix = 0;
				lines++;
			end
			if (sync.vblank && !prev_vblank) begin
				check_count("de lines per frame", lines, `TFT_V_ACTIVE);
				// First pixel of a frame comes before the refill
				if (stalls > 1) begin
					mid_frames++;
				end
				frames_done++;
				if (frames_done == cur_frames) begin
					check_flag("mid-frame underrun", mid_frames != 0, cur_slow);
				end
				widx = 0;
				stalls = 0;
				lines = 0;
			end
			prev_pix = sync.pix_clk;
			prev_de = sync.de;
			prev_vblank = sync.vblank;
		end
	end

	int cycles = 0;

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		int total;
		int row_err;
		void'($urandom(32'h30b9));
		checks = 0;
		errors = 0;
		total = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			total += rows[r].frames;
		end
		limit = total * CYC_FRAME + NUM_ROWS * RESET_CYCLES + 2 * CYC_FRAME;
		for (int r = 0; r < NUM_ROWS; r++) begin
			row_err = errors;
			cur_rdy_delay = rows[r].rdy_delay;
			cur_lat = rows[r].lat + int'($urandom % 3);
			cur_gap = rows[r].gap;
			cur_frames = rows[r].frames;
			cur_slow = rows[r].slow;
			@(posedge clk);
			n_reset <= 1'b0;
			repeat (RESET_CYCLES) @(posedge clk);
			n_reset <= 1'b1;
			@(posedge clk);
			while (frames_done < cur_frames) begin
				@(posedge clk);
			end
			$display("row %0d: rdy delay %0d, latency %0d, gap %0d, %0d frames, %0d %s, %0d errors",
				r, cur_rdy_delay, cur_lat, cur_gap, cur_frames, mid_frames,
				"with mid-frame underrun", errors - row_err);
		end
		$display("%0d rows, %0d checks, %0d errors", NUM_ROWS, checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/tft_display.sv
`timescale 1ns/1ps
`default_nettype none

module tft_display
	import tft_pkg::*;
(
	input  logic      clk,
	input  logic      n_reset,

	// Frame buffer memory
	output mem_req_t  mem_req,
	input  mem_rsp_t  mem_rsp,

	// Panel
	output tft_sync_t sync,
	output pixel_t    pixel,
	output logic      underrun
);

	// Raw timing, de still zero
	tft_sync_t timing_sync;

	tft_timing i_timing (
		.clk     (clk),
		.n_reset (n_reset),
		.sync    (timing_sync)
	);

	// Fetch adds de and delays the bundle to match the pixel
	tft_fetch i_fetch (
		.clk      (clk),
		.n_reset  (n_reset),
		.sync_in  (timing_sync),
		.sync_out (sync),
		.pixel    (pixel),
		.underrun (underrun),
		.mem_req  (mem_req),
		.mem_rsp  (mem_rsp)
	);

endmodule

`default_nettype wire

// File: hw/tft_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "tft_cfg.svh"

module tft_fetch
	import tft_pkg::*;
(
	input  logic      clk,
	input  logic      n_reset,
	input  tft_sync_t sync_in,
	output tft_sync_t sync_out,
	output pixel_t    pixel,
	output logic      underrun,
	output mem_req_t  mem_req,
	input  mem_rsp_t  mem_rsp
);

	localparam int AW = `TFT_FIFO_AW;
	localparam int LW = AW + 1;
	localparam logic [LW-1:0] BURST     = LW'(`TFT_BURST);
	localparam logic [LW-1:0] FILL_STOP = LW'(`TFT_FILL_STOP);
	localparam tft_sync_t SYNC_IDLE = '{pix_clk: 1'b0, hblank: 1'b1, vblank: 1'b1, de: 1'b0};

	// Pixel clock edge detect on clk, strobe registered once more
	logic pix_s1;
	logic pix_s2;
	logic pix_strobe;
	logic pop;
	logic pop_ok;

	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			pix_s1     <= 1'b0;
			pix_s2     <= 1'b0;
			pix_strobe <= 1'b0;
		end else begin
			pix_s1     <= sync_in.pix_clk;
			pix_s2     <= pix_s1;
			pix_strobe <= pix_s1 & ~pix_s2;
		end
	end

	// Active pixel, blanking levels are stable for the whole pixel period
	assign pop = pix_strobe & ~sync_in.hblank & ~sync_in.vblank;

	// Frame reset, high through vblank and out of reset
	logic frame_rst;

	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			frame_rst <= 1'b1;
		end else begin
			frame_rst <= sync_in.vblank;
		end
	end

	// FIFO pointers and storage
	logic [AW-1:0] head;
	logic [AW-1:0] tail;
	logic          empty;
	logic          overrun;
	logic          rd_empty;
	rgb565_t       rdata;

	fifo_sync i_fifo (
		.clk     (clk),
		.n_reset (n_reset),
		.flush   (frame_rst),
		.wrreq   (mem_rsp.ifrdy),
		.rdack   (pop_ok),
		.head    (head),
		.tail    (tail),
		.empty   (empty),
		.full    (),
		.overrun (overrun)
	);

	ram_dual i_ram (
		.clk     (clk),
		.wr_addr (head),
		.rd_addr (tail),
		.wren    (mem_rsp.ifrdy & ~overrun),
		.wdata   (rgb565_t'(mem_rsp.data)),
		.rdata   (rdata)
	);

	// Empty as seen by the last RAM read, so rdata matches the popped word
	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			rd_empty <= 1'b1;
		end else begin
			rd_empty <= empty;
		end
	end

	assign pop_ok = pop & ~rd_empty;

	// Fill level counts stored words plus words still in flight
	logic          req;
	logic          accept;
	logic [LW-1:0] level;
	logic [LW-1:0] level_next;

	assign accept = req & mem_rsp.rdy;

	always_comb begin
		level_next = level;
		if (accept) begin
			level_next = level_next + BURST;
		end
		if (pop_ok) begin
			level_next = level_next - 1'b1;
		end
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			level <= '0;
		end else if (frame_rst) begin
			level <= '0;
		end else begin
			level <= level_next;
		end
	end

	// Request level, held until the level reaches the stop mark
	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			req <= 1'b0;
		end else begin
			req <= ~frame_rst & (level_next < FILL_STOP);
		end
	end

	// Burst address, back to the base every frame
	logic [23:0] addr;

	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			addr <= `TFT_FB_BASE;
		end else if (frame_rst) begin
			addr <= `TFT_FB_BASE;
		end else if (accept) begin
			addr <= addr + 24'(`TFT_BURST);
		end
	end

	assign mem_req = '{req: req, addr: addr};

	// RGB565 to RGB888, low bits zero
	// An empty pop keeps the previous pixel
	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			pixel <= '0;
		end else if (pop_ok) begin
			pixel <= '{r: {rdata.r, 3'b000}, g: {rdata.g, 2'b00}, b: {rdata.b, 3'b000}};
		end
	end

	// Sticky until the next frame reset
	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			underrun <= 1'b0;
		end else if (frame_rst) begin
			underrun <= 1'b0;
		end else if (pop & rd_empty) begin
			underrun <= 1'b1;
		end
	end

	// Three stage delay so sync lines up with the pixel register
	tft_sync_t sync_d1;
	tft_sync_t sync_d2;

	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			sync_d1  <= SYNC_IDLE;
			sync_d2  <= SYNC_IDLE;
			sync_out <= SYNC_IDLE;
		end else begin
			sync_d1 <= '{
				pix_clk: sync_in.pix_clk,
				hblank:  sync_in.hblank,
				vblank:  sync_in.vblank,
				de:      ~sync_in.hblank & ~sync_in.vblank
			};
			sync_d2  <= sync_d1;
			sync_out <= sync_d2;
		end
	end

endmodule

`default_nettype wire

// File: hw/tft_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "tft_cfg.svh"

module tft_timing
	import tft_pkg::*;
(
	input  logic      clk,
	input  logic      n_reset,
	output tft_sync_t sync
);

	localparam int H_TOTAL = `TFT_H_ACTIVE + `TFT_H_BLANK;
	localparam int V_TOTAL = `TFT_V_ACTIVE + `TFT_V_BLANK;
	localparam int HW      = $clog2(H_TOTAL);
	localparam int VW      = $clog2(V_TOTAL);
	localparam int DW      = $clog2(`TFT_PIX_DIV);
	localparam int HALF    = `TFT_PIX_DIV / 2;

	logic [DW-1:0] div_cnt;
	logic          pix_clk;
	logic          pix_rise;
	logic          pix_fall;
	logic [HW-1:0] h_cnt;
	logic [HW-1:0] h_next;
	logic          h_last;
	logic [VW-1:0] v_cnt;
	logic [VW-1:0] v_next;
	logic          v_last;
	logic          hblank;
	logic          vblank;

	// Pixel clock divider, low for the first half period
	assign pix_rise = (div_cnt == DW'(HALF - 1));
	assign pix_fall = (div_cnt == DW'(`TFT_PIX_DIV - 1));

	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			div_cnt <= '0;
			pix_clk <= 1'b0;
		end else begin
			div_cnt <= pix_fall ? '0 : div_cnt + 1'b1;
			if (pix_rise) begin
				pix_clk <= 1'b1;
			end else if (pix_fall) begin
				pix_clk <= 1'b0;
			end
		end
	end

	// Next pixel and line position
	assign h_last = (h_cnt == HW'(H_TOTAL - 1));
	assign v_last = (v_cnt == VW'(V_TOTAL - 1));
	assign h_next = h_last ? '0 : h_cnt + 1'b1;

	always_comb begin
		v_next = v_cnt;
		if (h_last) begin
			v_next = v_last ? '0 : v_cnt + 1'b1;
		end
	end

	// Counters and blanking move together with the pix_clk rising edge
	// Reset parks on the last blank pixel so the first rise starts line 0
	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			h_cnt  <= HW'(H_TOTAL - 1);
			v_cnt  <= VW'(V_TOTAL - 1);
			hblank <= 1'b1;
			vblank <= 1'b1;
		end else if (pix_rise) begin
			h_cnt  <= h_next;
			v_cnt  <= v_next;
			hblank <= (h_next >= HW'(`TFT_H_ACTIVE));
			vblank <= (v_next >= VW'(`TFT_V_ACTIVE));
		end
	end

	// de is filled in by the fetch block
	assign sync = '{pix_clk: pix_clk, hblank: hblank, vblank: vblank, de: 1'b0};

endmodule

`default_nettype wire

// File: hw/ram_dual.sv
`timescale 1ns/1ps
`default_nettype none

`include "tft_cfg.svh"

module ram_dual
	import tft_pkg::*;
(
	input  logic                    clk,
	input  logic [`TFT_FIFO_AW-1:0] wr_addr,
	input  logic [`TFT_FIFO_AW-1:0] rd_addr,
	input  logic                    wren,
	input  rgb565_t                 wdata,
	output rgb565_t                 rdata
);

	localparam int DEPTH = 2 ** `TFT_FIFO_AW;

	rgb565_t mem [DEPTH];

	// Write port
	always_ff @(posedge clk) begin
		if (wren) begin
			mem[wr_addr] <= wdata;
		end
	end

	// Registered read, a word written one edge earlier is visible
	always_ff @(posedge clk) begin
		rdata <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: hw/fifo_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "tft_cfg.svh"

module fifo_sync (
	input  logic                    clk,
	input  logic                    n_reset,
	input  logic                    flush,
	input  logic                    wrreq,
	input  logic                    rdack,
	output logic [`TFT_FIFO_AW-1:0] head,
	output logic [`TFT_FIFO_AW-1:0] tail,
	output logic                    empty,
	output logic                    full,
	output logic                    overrun
);

	localparam int AW = `TFT_FIFO_AW;

	// Pointers carry one extra wrap bit
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        wr_en;
	logic        rd_en;

	// Same index, different lap means full
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
		(wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// A write into a full FIFO is dropped
	assign overrun = wrreq & full;

	assign wr_en = wrreq & ~full;
	assign rd_en = rdack & ~empty;

	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			wr_ptr <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (~n_reset) begin
			rd_ptr <= '0;
		end else if (flush) begin
			rd_ptr <= '0;
		end else if (rd_en) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// RAM addresses drop the wrap bit
	assign head = wr_ptr[AW-1:0];
	assign tail = rd_ptr[AW-1:0];

endmodule

`default_nettype wire

// File: hw/tft_pkg.sv
`default_nettype none

package tft_pkg;

	// Request toward the frame buffer memory
	typedef struct packed {
		logic        req;
		logic [23:0] addr;
	} mem_req_t;

	// Response from memory
	// rdy accepts a burst, ifrdy marks each returned word
	typedef struct packed {
		logic        rdy;
		logic        ifrdy;
		logic [15:0] data;
	} mem_rsp_t;

	// Panel timing bundle
	typedef struct packed {
		logic pix_clk;
		logic hblank;
		logic vblank;
		logic de;
	} tft_sync_t;

	// Frame buffer word, red in the top bits
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	// Panel pixel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

endpackage

`default_nettype wire

// File: hw/tft_cfg.svh
`ifndef TFT_CFG_SVH
`define TFT_CFG_SVH

// Panel geometry in pixels and lines
`define TFT_H_ACTIVE 16
`define TFT_H_BLANK 6
`define TFT_V_ACTIVE 4
`define TFT_V_BLANK 2

// clk cycles per pixel clock period, even
`define TFT_PIX_DIV 8

// Pixel FIFO, 2**AW entries of one RGB565 word each
`define TFT_FIFO_AW 5

// Words returned per accepted memory request
`define TFT_BURST 4

// Stop requesting at or above this fill level
`define TFT_FILL_STOP 24

// First word of the frame buffer
`define TFT_FB_BASE 24'hF00000

`endif
